/* source/ll_st_pkg.sv */
// Single clock, single channel only; gen1 layout splits the 73-bit beat around the marker bit
package ll_st_pkg;

  //////////////////////////////////////////////////
  // Beat and PHY widths

  // Stored beat {tlast, tkeep[7:0], tdata[63:0]}
  localparam int st_data_width = 73;
  localparam int phy_width = 80;

  // Gen1 splits the beat into a low and a high part
  localparam int gen1_lo_width = 37;
  localparam int gen1_hi_width = st_data_width - gen1_lo_width;

  // Receive FIFO size, depth must be a power of two
  localparam int rx_fifo_depth = 128;
  localparam int rx_fifo_ptr_width = 7;

  //////////////////////////////////////////////////
  // Debug status layout

  localparam int dbg_level_lsb = 0;
  localparam int dbg_drop_lsb = 8;
  localparam int dbg_online_bit = 16;
  localparam int dbg_empty_bit = 17;

  // TX PHY word, every other bit is zero
  localparam int tx_credit_bit = 0;
  localparam int tx_strobe_bit = 1;

  //////////////////////////////////////////////////
  // Received PHY word, two layouts of one word

  typedef union packed {
    // Gen2: contiguous data, marker at the top
    struct packed {
      logic marker;
      logic [3:0] spare;
      logic [st_data_width-1:0] data;
      logic strobe;
      logic push;
    } gen2;
    // Gen1: data split around marker at bit 39
    struct packed {
      logic [2:0] spare_hi;
      logic [gen1_hi_width-1:0] data_hi;
      logic spare_lo;
      logic marker;
      logic [gen1_lo_width-1:0] data_lo;
      logic strobe;
      logic push;
    } gen1;
  } rx_phy_word_t;

endpackage

/* source/ll_auto_sync.sv */
// Delay counts are sampled live and should stay constant while the link is online
`timescale 1ns/1ns

module ll_auto_sync (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  input  logic [15:0] delay_z_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        tx_auto_stb_userbit
);

  // RX hold-off counter
  logic [15:0] rx_cnt;
  // TX hold-off counter, one bit wider for delay_y + 1
  logic [16:0] tx_cnt;
  // Strobe burst length counter
  logic [15:0] stb_cnt;
  logic rx_ready;
  logic tx_ready;
  logic tx_rise;

  // Hold-off expired
  assign rx_ready = rx_cnt >= delay_x_value;
  assign tx_ready = tx_cnt > {1'b0, delay_y_value};

  // TX side about to come online this edge
  assign tx_rise = tx_online && tx_ready && !tx_online_delay;

  //////////////////////////////////////////////////
  // RX online delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_cnt <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online) begin
      // Drop immediately and restart the count
      rx_cnt <= '0;
      rx_online_delay <= 1'b0;
    end else begin
      if (!rx_ready) begin
        rx_cnt <= rx_cnt + 16'd1;
      end
      rx_online_delay <= rx_ready;
    end
  end

  //////////////////////////////////////////////////
  // TX online delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_cnt <= '0;
      tx_online_delay <= 1'b0;
    end else if (!tx_online) begin
      tx_cnt <= '0;
      tx_online_delay <= 1'b0;
    end else begin
      if (!tx_ready) begin
        tx_cnt <= tx_cnt + 17'd1;
      end
      tx_online_delay <= tx_ready;
    end
  end

  //////////////////////////////////////////////////
  // Strobe burst, starts with tx_online_delay

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_auto_stb_userbit <= 1'b0;
      stb_cnt <= '0;
    end else if (!tx_online) begin
      tx_auto_stb_userbit <= 1'b0;
      stb_cnt <= '0;
    end else if (tx_rise) begin
      // Zero length means no burst at all
      tx_auto_stb_userbit <= delay_z_value != 16'd0;
      stb_cnt <= 16'd1;
    end else if (tx_auto_stb_userbit) begin
      if (stb_cnt >= delay_z_value) begin
        tx_auto_stb_userbit <= 1'b0;
      end else begin
        stb_cnt <= stb_cnt + 16'd1;
      end
    end
  end

  // Delayed RX online must follow a low rx_online within one edge
  rx_delay_follows_online: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    !rx_online |=> !rx_online_delay
  ) else $error("rx_online_delay high after rx_online low");

endmodule

/* source/ll_rx_fifo.sv */
// Caller must never push when full or pop when empty; rd_data is undefined while empty
`timescale 1ns/1ns

module ll_rx_fifo
  import ll_st_pkg::*;
(
  input  logic                         clk_wr,
  input  logic                         rst_n,
  input  logic                         push,
  input  logic                         pop,
  input  logic [st_data_width-1:0]     wr_data,
  output logic [st_data_width-1:0]     rd_data,
  output logic                         full,
  output logic                         empty,
  output logic [rx_fifo_ptr_width:0]   level
);

  // Beat storage
  logic [st_data_width-1:0] mem [rx_fifo_depth];

  // Pointers wrap on their own, depth is 2**ptr_width
  logic [rx_fifo_ptr_width-1:0] wr_ptr;
  logic [rx_fifo_ptr_width-1:0] rd_ptr;
  // Entries held
  logic [rx_fifo_ptr_width:0] count;

  //////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk_wr) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Head entry
  assign rd_data = mem[rd_ptr];

  //////////////////////////////////////////////////
  // Pointers and count

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Flags straight from the count
  assign full = count == (rx_fifo_ptr_width + 1)'(rx_fifo_depth);
  assign empty = count == '0;
  assign level = count;

  // Upstream gating must keep pushes off a full FIFO
  no_push_when_full: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    push |-> !full
  ) else $error("FIFO push while full");

  // Reader valid must track occupancy
  no_pop_when_empty: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    pop |-> !empty
  ) else $error("FIFO pop while empty");

endmodule

/* source/ll_receive.sv */
// rx_online must be the delayed online level; debug status lags the FIFO state by one cycle
`timescale 1ns/1ns

module ll_receive
  import ll_st_pkg::*;
(
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       rx_online,
  input  logic                       rx_i_pushbit,
  input  logic [st_data_width-1:0]   rx_i_data,
  input  logic                       user_i_ready,
  output logic                       user_i_valid,
  output logic [st_data_width-1:0]   rxfifo_i_data,
  output logic                       tx_i_credit,
  output logic [31:0]                rx_i_debug_status
);

  logic push_req;
  logic fifo_push;
  logic fifo_pop;
  logic fifo_full;
  logic fifo_empty;
  logic [rx_fifo_ptr_width:0] fifo_level;
  // Saturating count of pushes lost to a full FIFO
  logic [7:0] drop_cnt;

  //////////////////////////////////////////////////
  // Write side

  // Pushes only count while online
  assign push_req = rx_i_pushbit && rx_online;
  assign fifo_push = push_req && !fifo_full;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      drop_cnt <= '0;
    end else if (push_req && fifo_full && drop_cnt != 8'hff) begin
      drop_cnt <= drop_cnt + 8'd1;
    end
  end

  ll_rx_fifo i_ll_rx_fifo (
    .clk_wr  (clk_wr),
    .rst_n   (rst_n),
    .push    (fifo_push),
    .pop     (fifo_pop),
    .wr_data (rx_i_data),
    .rd_data (rxfifo_i_data),
    .full    (fifo_full),
    .empty   (fifo_empty),
    .level   (fifo_level)
  );

  //////////////////////////////////////////////////
  // Read side

  // Handshake
  assign fifo_pop = user_i_valid && user_i_ready;

  // Valid one cycle behind non-empty
  // Drops when the last entry leaves
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      user_i_valid <= 1'b0;
      tx_i_credit <= 1'b0;
    end else begin
      user_i_valid <= !fifo_empty && !(fifo_pop && fifo_level == 1);
      // One credit per beat taken
      tx_i_credit <= fifo_pop;
    end
  end

  //////////////////////////////////////////////////
  // Debug status

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_i_debug_status <= '0;
    end else begin
      rx_i_debug_status <= '0;
      rx_i_debug_status[dbg_level_lsb +: rx_fifo_ptr_width + 1] <= fifo_level;
      rx_i_debug_status[dbg_drop_lsb +: 8] <= drop_cnt;
      rx_i_debug_status[dbg_online_bit] <= rx_online;
      rx_i_debug_status[dbg_empty_bit] <= fifo_empty;
    end
  end

  // AXI-stream hold rule on the user side
  valid_held_until_ready: assert property (
    @(posedge clk_wr) disable iff (!rst_n)
    user_i_valid && !user_i_ready |=> user_i_valid && $stable(rxfifo_i_data)
  ) else $error("user valid or data changed without ready");

endmodule

/* source/axi_st_d64_slave_concat.sv */
// m_gen2_mode must be static while words flow; RX marker and spare bits are not used
`timescale 1ns/1ns

module axi_st_d64_slave_concat
  import ll_st_pkg::*;
(
  input  logic                       clk_wr,
  input  logic                       rst_n,
  input  logic                       m_gen2_mode,
  input  logic [phy_width-1:0]       rx_phy0,
  output logic [phy_width-1:0]       tx_phy0,
  output logic                       rx_st_pushbit,
  output logic [st_data_width-1:0]   rx_st_data,
  input  logic                       tx_st_credit,
  input  logic                       tx_online,
  input  logic                       tx_stb_userbit
);

  // Incoming word seen through both layouts
  rx_phy_word_t rx_word;
  logic rx_push_dec;
  logic [st_data_width-1:0] rx_data_dec;

  //////////////////////////////////////////////////
  // Receive unpack

  assign rx_word = rx_phy0;

  // Push sits at bit 0 in both layouts
  assign rx_push_dec = rx_word.gen2.push;

  // Gen1 rejoins the halves around the marker
  assign rx_data_dec = m_gen2_mode ? rx_word.gen2.data :
                       {rx_word.gen1.data_hi, rx_word.gen1.data_lo};

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_st_pushbit <= 1'b0;
    end else begin
      rx_st_pushbit <= rx_push_dec;
    end
  end

  // Payload only, qualified by the push bit
  always_ff @(posedge clk_wr) begin
    rx_st_data <= rx_data_dec;
  end

  //////////////////////////////////////////////////
  // Transmit pack

  // Credits are held back until TX is online
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= '0;
      tx_phy0[tx_credit_bit] <= tx_st_credit && tx_online;
      tx_phy0[tx_strobe_bit] <= tx_stb_userbit;
    end
  end

endmodule

/* source/axi_st_d64_slave_top.sv */
// Single channel on clk_wr only; no push override, marker or transmit data path
`timescale 1ns/1ns

module axi_st_d64_slave_top
  import ll_st_pkg::*;
(
  input  logic                   clk_wr,
  input  logic                   rst_n,

  // Link control
  input  logic                   tx_online,
  input  logic                   rx_online,

  // PHY words
  output logic [phy_width-1:0]   tx_phy0,
  input  logic [phy_width-1:0]   rx_phy0,

  // AXI-stream to the user
  output logic [7:0]             user_tkeep,
  output logic [63:0]            user_tdata,
  output logic                   user_tlast,
  output logic                   user_tvalid,
  input  logic                   user_tready,

  output logic [31:0]            rx_st_debug_status,

  // Configuration
  input  logic                   m_gen2_mode,
  // Word alignment time for the RX side
  input  logic [15:0]            delay_x_value,
  input  logic [15:0]            delay_y_value,
  input  logic [15:0]            delay_z_value
);

  logic rx_st_pushbit;
  logic [st_data_width-1:0] rx_st_data;
  logic [st_data_width-1:0] rxfifo_st_data;
  logic user_st_valid;
  logic user_st_ready;
  logic tx_st_credit;
  logic tx_online_delay;
  logic rx_online_delay;
  logic tx_auto_stb_userbit;

  //////////////////////////////////////////////////
  // Online sequencing

  ll_auto_sync i_ll_auto_sync (
    .clk_wr              (clk_wr),
    .rst_n               (rst_n),
    .tx_online           (tx_online),
    .rx_online           (rx_online),
    .delay_x_value       (delay_x_value),
    .delay_y_value       (delay_y_value),
    .delay_z_value       (delay_z_value),
    .tx_online_delay     (tx_online_delay),
    .rx_online_delay     (rx_online_delay),
    .tx_auto_stb_userbit (tx_auto_stb_userbit)
  );

  //////////////////////////////////////////////////
  // Receive buffer and credits

  ll_receive i_ll_receive (
    .clk_wr            (clk_wr),
    .rst_n             (rst_n),
    .rx_online         (rx_online_delay),
    .rx_i_pushbit      (rx_st_pushbit),
    .rx_i_data         (rx_st_data),
    .user_i_ready      (user_st_ready),
    .user_i_valid      (user_st_valid),
    .rxfifo_i_data     (rxfifo_st_data),
    .tx_i_credit       (tx_st_credit),
    .rx_i_debug_status (rx_st_debug_status)
  );

  //////////////////////////////////////////////////
  // PHY side

  axi_st_d64_slave_concat i_axi_st_d64_slave_concat (
    .clk_wr         (clk_wr),
    .rst_n          (rst_n),
    .m_gen2_mode    (m_gen2_mode),
    .rx_phy0        (rx_phy0),
    .tx_phy0        (tx_phy0),
    .rx_st_pushbit  (rx_st_pushbit),
    .rx_st_data     (rx_st_data),
    .tx_st_credit   (tx_st_credit),
    .tx_online      (tx_online_delay),
    .tx_stb_userbit (tx_auto_stb_userbit)
  );

  // Beat fields, tlast on top
  assign user_tlast = rxfifo_st_data[st_data_width-1];
  assign user_tkeep = rxfifo_st_data[64 +: 8];
  assign user_tdata = rxfifo_st_data[63:0];
  assign user_tvalid = user_st_valid;
  assign user_st_ready = user_tready;

endmodule

/* tests/tb_axi_st_d64_slave.sv */
// Single clock, fixed seed; the scoreboard assumes the FIFO never fills except in the overflow phase
`timescale 1ns/1ns

module tb_axi_st_d64_slave
  import ll_st_pkg::*;
();

  localparam int delay_x = 10;
  localparam int delay_y = 4;
  localparam int delay_z = 6;
  // Strobe window on tx_phy0, in edges since tx_online was driven
  localparam int stb_first = delay_y + 3;
  localparam int stb_last = stb_first + delay_z - 1;
  localparam int data_beats = 100;
  localparam int overflow_pushes = 130;
  // Roughly twice the ~900 cycles of the whole sequence
  localparam int max_cycles = 2000;

  logic clk_wr;
  logic rst_n;
  logic tx_online;
  logic rx_online;
  logic [phy_width-1:0] tx_phy0;
  logic [phy_width-1:0] rx_phy0;
  logic [7:0] user_tkeep;
  logic [63:0] user_tdata;
  logic user_tlast;
  logic user_tvalid;
  logic user_tready;
  logic [31:0] rx_st_debug_status;
  logic m_gen2_mode;
  logic [15:0] delay_x_value;
  logic [15:0] delay_y_value;
  logic [15:0] delay_z_value;

  integer seed;
  int mismatch_count;
  int failure_count;
  int cycles;
  // Edges since rx_online / tx_online were driven high
  int rx_age;
  int tx_age;
  // 0 ready low, 1 random, 2 ready high
  int ready_mode;
  int hs_count;
  int credit_count;
  logic [st_data_width-1:0] sb [$];
  logic [st_data_width-1:0] exp_head;
  logic exp_any;
  logic hs;

  assign hs = user_tvalid && user_tready;

  axi_st_d64_slave_top i_axi_st_d64_slave_top (.*);

  always #20 clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////
  // One clock edge of the PHY and user models

  task automatic step();
    int r;
    @(posedge clk_wr);
    // Pre-edge DUT values, as the DUT saw them
    if (hs) begin
      if (sb.size() > 0) void'(sb.pop_front());
      if (tx_age > stb_last) hs_count++;
    end
    if (tx_phy0[tx_credit_bit]) credit_count++;
    exp_any = sb.size() != 0;
    exp_head = exp_any ? sb[0] : '0;
    if (rx_online && rx_age < 100000) rx_age++;
    if (tx_online && tx_age < 100000) tx_age++;
    r = $random(seed);
    case (ready_mode)
      0: user_tready <= 1'b0;
      1: user_tready <= r[0];
      default: user_tready <= 1'b1;
    endcase
  endtask

  // Random beat in the current layout; queued only if the DUT must take it
  task automatic drive_push();
    rx_phy_word_t w;
    logic [st_data_width-1:0] beat;
    int lo;
    int hi;
    int top;
    lo = $random(seed);
    hi = $random(seed);
    top = $random(seed);
    beat = {top[8:0], hi, lo};
    w = '0;
    if (m_gen2_mode) begin
      w.gen2.push = 1'b1;
      w.gen2.data = beat;
    end else begin
      w.gen1.push = 1'b1;
      {w.gen1.data_hi, w.gen1.data_lo} = beat;
    end
    if (rx_age >= delay_x && sb.size() < rx_fifo_depth) sb.push_back(beat);
    rx_phy0 <= w;
  endtask

  task automatic wait_drain();
    while (sb.size() != 0) step();
    repeat (4) step();
  endtask

  // Pushes start right away, so the first ones fall inside the RX hold-off
  task automatic run_data_phase(input logic gen2);
    int r;
    int sent;
    sent = 0;
    step();
    m_gen2_mode <= gen2;
    rx_online <= 1'b1;
    rx_age = 0;
    ready_mode = 1;
    while (sent < data_beats) begin
      step();
      r = $random(seed);
      if (r[0]) begin
        drive_push();
        sent++;
      end else begin
        rx_phy0 <= '0;
      end
    end
    step();
    rx_phy0 <= '0;
    wait_drain();
    rx_online <= 1'b0;
    rx_age = 0;
    repeat (3) step();
  endtask

  task automatic check_field(input string name, input int got, input int exp);
    assert (got == exp) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////////////////
  // Checks

  reset_state: assert property (@(posedge clk_wr)
    $rose(rst_n) |-> !user_tvalid && tx_phy0 == '0 && rx_st_debug_status == '0)
    else begin
      mismatch_count++;
      $display(
        "mismatch at %0t: user_tvalid/tx_phy0/rx_st_debug_status expected 0/0/0 got %0b/%h/%h",
        $time, $sampled(user_tvalid), $sampled(tx_phy0), $sampled(rx_st_debug_status));
    end

  beat_matches: assert property (@(posedge clk_wr) disable iff (!rst_n)
    hs |-> {user_tlast, user_tkeep, user_tdata} == exp_head)
    else begin
      mismatch_count++;
      $display("mismatch at %0t: user beat {tlast,tkeep,tdata} expected %h got %h", $time,
               $sampled(exp_head), $sampled({user_tlast, user_tkeep, user_tdata}));
    end

  beat_expected: assert property (@(posedge clk_wr) disable iff (!rst_n)
    user_tvalid |-> exp_any)
    else begin
      failure_count++;
      $display("Error at %0t: user_tvalid is high but no beat was accepted", $time);
    end

  // Credit two edges after its handshake once TX is settled
  credit_follows: assert property (@(posedge clk_wr) disable iff (!rst_n)
    hs && tx_age > stb_last |-> ##2 tx_phy0[tx_credit_bit])
    else begin
      mismatch_count++;
      $display("mismatch at %0t: tx_phy0[credit] expected 1 got 0", $time);
    end

  credit_not_early: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy0[tx_credit_bit] |-> $past(hs, 2))
    else begin
      mismatch_count++;
      $display("mismatch at %0t: tx_phy0[credit] expected 0 got 1", $time);
    end

  strobe_window: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_phy0[tx_strobe_bit] == (tx_age >= stb_first && tx_age <= stb_last))
    else begin
      mismatch_count++;
      $display("mismatch at %0t: tx_phy0[strobe] expected %0b got %0b", $time,
               !$sampled(tx_phy0[tx_strobe_bit]), $sampled(tx_phy0[tx_strobe_bit]));
    end

  always @(posedge clk_wr) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////
  // Sequence

  initial begin
    seed = 32'hd66b7ec6;
    clk_wr = 1'b0;
    rst_n = 1'b0;
    tx_online = 1'b0;
    rx_online = 1'b0;
    rx_phy0 = '0;
    user_tready = 1'b0;
    m_gen2_mode = 1'b1;
    delay_x_value = 16'(delay_x);
    delay_y_value = 16'(delay_y);
    delay_z_value = 16'(delay_z);
    mismatch_count = 0;
    failure_count = 0;
    cycles = 0;
    rx_age = 0;
    tx_age = 0;
    ready_mode = 0;
    hs_count = 0;
    credit_count = 0;
    exp_head = '0;
    exp_any = 1'b0;
    repeat (2) step();
    rst_n <= 1'b1;
    step();
    tx_online <= 1'b1;
    repeat (30) step();
    run_data_phase(1'b1);
    run_data_phase(1'b0);
    // Overflow with the user stalled
    ready_mode = 0;
    step();
    rx_online <= 1'b1;
    rx_age = 0;
    repeat (delay_x + 2) step();
    repeat (overflow_pushes) begin
      step();
      drive_push();
    end
    step();
    rx_phy0 <= '0;
    repeat (5) step();
    check_field("debug level", rx_st_debug_status[dbg_level_lsb +: 8], rx_fifo_depth);
    check_field("debug drops", rx_st_debug_status[dbg_drop_lsb +: 8],
                overflow_pushes - rx_fifo_depth);
    check_field("debug online", rx_st_debug_status[dbg_online_bit], 1);
    check_field("debug empty", rx_st_debug_status[dbg_empty_bit], 0);
    ready_mode = 2;
    wait_drain();
    check_field("tx_phy0 credit count", credit_count, hs_count);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
source/ll_st_pkg.sv
source/ll_auto_sync.sv
source/ll_rx_fifo.sv
source/ll_receive.sv
source/axi_st_d64_slave_concat.sv
source/axi_st_d64_slave_top.sv
tests/tb_axi_st_d64_slave.sv
